//--- Makefile
TOP := tb_exec_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// data path and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_SYSTEM = 7'b1110011
	} op_e;

	// alu function, {instr[30], funct3} for the arithmetic ops
	// slt / sltu double as blt / bltu compares
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_GE   = 4'b1001,
		ALU_GEU  = 4'b1010,
		ALU_EQ   = 4'b1011,
		ALU_NE   = 4'b1100,
		ALU_SRA  = 4'b1101
	} alu_fn_e;

	// source of the written back value
	typedef enum logic [1:0] {
		FN_ALU   = 2'b00,
		FN_PC4   = 2'b01,
		FN_IMM   = 2'b10,
		FN_PCIMM = 2'b11
	} fn_sel_e;

	// second alu operand
	typedef enum logic [1:0] {
		OPB_REG   = 2'b00,
		OPB_IMM   = 2'b01,
		OPB_SHAMT = 2'b10
	} opb_sel_e;

endpackage

`default_nettype wire

//--- decode/imm_gen.sv
`default_nettype none

module imm_gen (
	input  logic [31:0] i_instr,
	output logic [31:0] o_imm
);

	logic [6:0]  opcode;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] imm_b;

	assign opcode = i_instr[6:0];

	// sign bit is always instr[31]
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
	assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};

	always_comb begin
		case (opcode)
			// shifts take imm[4:0] of the i format later on
			rv_pkg::OPC_OP_IMM,
			rv_pkg::OPC_JALR,
			rv_pkg::OPC_LOAD:   o_imm = imm_i;
			rv_pkg::OPC_LUI,
			rv_pkg::OPC_AUIPC:  o_imm = imm_u;
			rv_pkg::OPC_JAL:    o_imm = imm_j;
			rv_pkg::OPC_BRANCH: o_imm = imm_b;
			default:            o_imm = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
`default_nettype none

module instr_decoder (
	input  logic               [31:0] i_instr,
	output rv_pkg::alu_fn_e           o_alu_fn,
	output rv_pkg::opb_sel_e          o_opb_sel,
	output rv_pkg::fn_sel_e           o_fn_sel,
	output logic                      o_we,
	output logic                      o_btype,
	output logic                      o_use_pc,
	output logic                      o_ex
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       instr_30;
	logic       we_raw;

	assign opcode   = i_instr[6:0];
	assign funct3   = i_instr[14:12];
	assign funct7   = i_instr[31:25];
	assign instr_30 = i_instr[30];

	always_comb begin
		// defaults, an add into nothing
		o_alu_fn  = rv_pkg::ALU_ADD;
		o_opb_sel = rv_pkg::OPB_REG;
		o_fn_sel  = rv_pkg::FN_ALU;
		we_raw    = 1'b0;
		o_btype   = 1'b0;
		o_use_pc  = 1'b0;
		o_ex      = 1'b0;
		case (opcode)
			rv_pkg::OPC_OP: begin
				we_raw = 1'b1;
				if (funct7 == 7'b0000000)
					o_alu_fn = rv_pkg::alu_fn_e'({1'b0, funct3});
				// sub and sra carry instr[30]
				else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
					o_alu_fn = rv_pkg::alu_fn_e'({instr_30, funct3});
				// funct7 0000001 is mul/div, no m unit here
				else
					o_ex = 1'b1;
			end
			rv_pkg::OPC_OP_IMM: begin
				we_raw    = 1'b1;
				o_opb_sel = rv_pkg::OPB_IMM;
				o_alu_fn  = rv_pkg::alu_fn_e'({1'b0, funct3});
				if (funct3 == 3'b001) begin
					o_opb_sel = rv_pkg::OPB_SHAMT;
					if (funct7 != 7'b0000000)
						o_ex = 1'b1;
				end else if (funct3 == 3'b101) begin
					// srli or srai by bit 30
					o_opb_sel = rv_pkg::OPB_SHAMT;
					o_alu_fn  = rv_pkg::alu_fn_e'({instr_30, funct3});
					if (funct7 != 7'b0000000 && funct7 != 7'b0100000)
						o_ex = 1'b1;
				end
			end
			rv_pkg::OPC_LUI: begin
				we_raw   = 1'b1;
				o_fn_sel = rv_pkg::FN_IMM;
			end
			rv_pkg::OPC_AUIPC: begin
				// pc goes in on operand a, alu adds the immediate
				we_raw    = 1'b1;
				o_use_pc  = 1'b1;
				o_opb_sel = rv_pkg::OPB_IMM;
				o_fn_sel  = rv_pkg::FN_PCIMM;
			end
			rv_pkg::OPC_JAL: begin
				we_raw   = 1'b1;
				o_fn_sel = rv_pkg::FN_PC4;
			end
			rv_pkg::OPC_JALR: begin
				we_raw    = 1'b1;
				o_opb_sel = rv_pkg::OPB_IMM;
				o_fn_sel  = rv_pkg::FN_PC4;
				if (funct3 != 3'b000)
					o_ex = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				o_btype = 1'b1;
				// blt/bltu reuse the slt/sltu codes
				case (funct3)
					3'b000:  o_alu_fn = rv_pkg::ALU_EQ;
					3'b001:  o_alu_fn = rv_pkg::ALU_NE;
					3'b100:  o_alu_fn = rv_pkg::ALU_SLT;
					3'b101:  o_alu_fn = rv_pkg::ALU_GE;
					3'b110:  o_alu_fn = rv_pkg::ALU_SLTU;
					3'b111:  o_alu_fn = rv_pkg::ALU_GEU;
					default: o_ex = 1'b1;
				endcase
			end
			// no data memory and no csr unit
			rv_pkg::OPC_LOAD,
			rv_pkg::OPC_STORE,
			rv_pkg::OPC_SYSTEM: o_ex = 1'b1;
			default:            o_ex = 1'b1;
		endcase
	end

	// an excepting instruction never writes back
	assign o_we = we_raw & ~o_ex;

endmodule

`default_nettype wire

//--- sim.f
common/rv_pkg.sv
verilog/instr_queue.sv
decode/instr_decoder.sv
decode/imm_gen.sv
verilog/regfile.sv
verilog/alu.sv
verilog/exec_core.sv
tests/tb_exec_core.sv

//--- tests/tb_exec_core.sv
`default_nettype none

module tb_exec_core;

	// rv32i major opcodes
	localparam logic [6:0] OPC_R      = 7'h33;
	localparam logic [6:0] OPC_I      = 7'h13;
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_AUIPC  = 7'h17;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	// about ten cycles per instruction sent
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int PAT_LEN        = 1024;

	logic        i_clk;
	logic        i_rst;
	logic        i_in_valid;
	logic [31:0] i_in_instr;
	logic [31:0] i_in_pc;
	logic        o_in_ready;
	logic        o_res_valid;
	logic        i_res_ready;
	logic [4:0]  o_res_rd;
	logic [31:0] o_res_data;
	logic        o_res_we;
	logic        o_res_taken;
	logic        o_res_ex;

	// model state, record is {rd, data, we, taken, ex}
	logic [31:0] mregs [32];
	logic [39:0] exp_q [$];
	logic [31:0] ins_q [$];
	logic [31:0] pc;
	logic        ready_pat [PAT_LEN];
	logic        rand_ready;
	integer      seed;
	int          err_count;
	int          other_count;
	int          cycles;

	exec_core i_dut (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_in_valid  (i_in_valid),
		.i_in_instr  (i_in_instr),
		.i_in_pc     (i_in_pc),
		.o_in_ready  (o_in_ready),
		.o_res_valid (o_res_valid),
		.i_res_ready (i_res_ready),
		.o_res_rd    (o_res_rd),
		.o_res_data  (o_res_data),
		.o_res_we    (o_res_we),
		.o_res_taken (o_res_taken),
		.o_res_ex    (o_res_ex)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// instruction word builders
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_R};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// arithmetic by funct3, alt is instr bit 30 for sub and sra
	function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	// expected record from the rv32i rules and the model registers
	function automatic logic [39:0] predict(input logic [31:0] instr, input logic [31:0] pc_v);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] res;
		logic        we;
		logic        taken;
		logic        ex;
		f3    = instr[14:12];
		f7    = instr[31:25];
		a     = mregs[instr[19:15]];
		b     = mregs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		res   = '0;
		we    = 1'b0;
		taken = 1'b0;
		ex    = 1'b0;
		case (instr[6:0])
			OPC_R: begin
				if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
					we  = 1'b1;
					res = alu_expect(f3, f7[5], a, b);
				end else
					ex = 1'b1;
			end
			OPC_I: begin
				if ((f3 == 3'd1 && f7 != 7'h00) ||
					(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))
					ex = 1'b1;
				else begin
					we  = 1'b1;
					res = alu_expect(f3, (f3 == 3'd5) && f7[5], a, imm_i);
				end
			end
			OPC_LUI: begin
				we  = 1'b1;
				res = {instr[31:12], 12'b0};
			end
			OPC_AUIPC: begin
				we  = 1'b1;
				res = pc_v + {instr[31:12], 12'b0};
			end
			OPC_JAL: begin
				we  = 1'b1;
				res = pc_v + 32'd4;
			end
			OPC_JALR: begin
				we  = (f3 == 3'd0);
				ex  = (f3 != 3'd0);
				res = pc_v + 32'd4;
			end
			OPC_BRANCH: begin
				case (f3)
					3'd0:    taken = (a == b);
					3'd1:    taken = (a != b);
					3'd4:    taken = $signed(a) < $signed(b);
					3'd5:    taken = $signed(a) >= $signed(b);
					3'd6:    taken = a < b;
					3'd7:    taken = a >= b;
					default: ex = 1'b1;
				endcase
			end
			// loads, stores, system, illegal
			default: ex = 1'b1;
		endcase
		return {instr[11:7], we ? res : 32'h0, we, taken, ex};
	endfunction

	task automatic check(input string what, input logic [39:0] got, input logic [39:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s: got %h expected %h", $time, what, got, exp);
		end
	endtask

	// hold the word until the queue takes it, then book the expected record
	task automatic send(input logic [31:0] instr);
		logic [39:0] rec;
		@(negedge i_clk);
		i_in_valid = 1'b1;
		i_in_instr = instr;
		i_in_pc    = pc;
		while (!o_in_ready)
			@(negedge i_clk);
		rec = predict(instr, pc);
		exp_q.push_back(rec);
		ins_q.push_back(instr);
		if (rec[2] && instr[11:7] != 5'd0)
			mregs[instr[11:7]] = rec[34:3];
		pc = pc + 32'd4;
	endtask

	task automatic wait_drain();
		@(negedge i_clk);
		i_in_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge i_clk);
		// last checked record leaves on the next edge
		@(negedge i_clk);
	endtask

	task automatic apply_reset();
		@(negedge i_clk);
		i_rst = 1'b1;
		repeat (8) @(negedge i_clk);
		i_rst = 1'b0;
		for (int r = 0; r < 32; r++)
			mregs[r] = '0;
		pc = '0;
		check("valid after reset", {39'b0, o_res_valid}, 40'd0);
		check("ready after reset", {39'b0, o_in_ready}, 40'd1);
	endtask

	task automatic test_reg_ops();
		logic [6:0]  f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
			7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
		logic [2:0]  f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
			3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic [31:0] rnd;
		for (int r = 1; r <= 4; r++) begin
			rnd = $random(seed);
			// x3 kept negative for sra
			if (r == 3)
				rnd[19] = 1'b1;
			send(u_word(rnd[19:0], 5'(r), OPC_LUI));
			send(i_word(rnd[31:20], 5'(r), 3'd0, 5'(r), OPC_I));
		end
		for (int k = 0; k < 10; k++) begin
			send(r_word(f7s[k], 5'd2, 5'd1, f3s[k], 5'(10 + k)));
			send(r_word(f7s[k], 5'd4, 5'd3, f3s[k], 5'(10 + k)));
		end
		// x0 write is dropped, then read back
		send(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
		send(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
	endtask

	task automatic test_imm_ops();
		logic [2:0]  f3s [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
		logic [31:0] rnd;
		for (int k = 0; k < 6; k++) begin
			rnd = $random(seed);
			send(i_word(rnd[11:0], 5'd1, f3s[k], 5'(14 + k), OPC_I));
			send(i_word(rnd[23:12], 5'd3, f3s[k], 5'(14 + k), OPC_I));
		end
		for (int s = 1; s <= 3; s += 2) begin
			rnd = $random(seed);
			send(i_word({7'h00, rnd[4:0]}, 5'(s), 3'd1, 5'd20, OPC_I));
			send(i_word({7'h00, rnd[9:5]}, 5'(s), 3'd5, 5'd21, OPC_I));
			send(i_word({7'h20, rnd[14:10]}, 5'(s), 3'd5, 5'd22, OPC_I));
		end
	endtask

	task automatic test_branches();
		logic [2:0]  f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		// equal, signed less, signed greater, random
		logic [4:0]  lhs [4] = '{5'd8, 5'd7, 5'd8, 5'd1};
		logic [4:0]  rhs [4] = '{5'd9, 5'd8, 5'd7, 5'd2};
		logic [31:0] rnd;
		send(i_word(12'hffb, 5'd0, 3'd0, 5'd7, OPC_I));
		send(i_word(12'h003, 5'd0, 3'd0, 5'd8, OPC_I));
		send(i_word(12'h003, 5'd0, 3'd0, 5'd9, OPC_I));
		for (int k = 0; k < 6; k++) begin
			for (int p = 0; p < 4; p++) begin
				rnd = $random(seed);
				send(b_word({rnd[12:1], 1'b0}, rhs[p], lhs[p], f3s[k]));
			end
		end
	endtask

	task automatic test_jumps();
		logic [31:0] rnd;
		rnd = $random(seed);
		pc  = {rnd[31:2], 2'b00};
		rnd = $random(seed);
		send(u_word(rnd[19:0], 5'd23, OPC_AUIPC));
		send(j_word({rnd[20:1], 1'b0}, 5'd24));
		send(j_word({rnd[31:12], 1'b0}, 5'd0));
		send(i_word(rnd[31:20], 5'd1, 3'd0, 5'd25, OPC_JALR));
		// link values land in the registers
		send(r_word(7'h00, 5'd0, 5'd24, 3'd0, 5'd26));
		send(r_word(7'h00, 5'd0, 5'd25, 3'd0, 5'd27));
	endtask

	task automatic test_exceptions();
		send(i_word(12'h123, 5'd0, 3'd0, 5'd11, OPC_I));
		send(i_word(12'h456, 5'd0, 3'd0, 5'd12, OPC_I));
		send(i_word(12'h789, 5'd0, 3'd0, 5'd13, OPC_I));
		// lw, sw, mul, ecall, illegal opcode
		send(i_word(12'h004, 5'd1, 3'd2, 5'd11, OPC_LOAD));
		send(s_word(12'h008, 5'd2, 5'd1, 3'd2));
		send(r_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd12));
		send(32'h00000073);
		send(i_word(12'h0ff, 5'd1, 3'd0, 5'd13, 7'h7f));
		send(r_word(7'h00, 5'd0, 5'd11, 3'd0, 5'd28));
		send(r_word(7'h00, 5'd0, 5'd12, 3'd0, 5'd29));
		send(r_word(7'h00, 5'd0, 5'd13, 3'd0, 5'd30));
	endtask

	task automatic test_stream();
		logic [31:0] rnd;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		rand_ready = 1'b1;
		for (int n = 0; n < 100; n++) begin
			rnd = $random(seed);
			f3  = rnd[3:1];
			alt = rnd[4] && (f3 == 3'd0 || f3 == 3'd5);
			if (rnd[0]) begin
				send(r_word(alt ? 7'h20 : 7'h00, rnd[19:15], rnd[14:10], f3, rnd[9:5]));
			end else begin
				imm = rnd[31:20];
				// shifts carry a five bit amount
				if (f3 == 3'd1)
					imm = {7'h00, rnd[24:20]};
				else if (f3 == 3'd5)
					imm = {rnd[4] ? 7'h20 : 7'h00, rnd[24:20]};
				send(i_word(imm, rnd[14:10], f3, rnd[9:5], OPC_I));
			end
		end
		wait_drain();
		rand_ready = 1'b0;
	endtask

	// output sink, checks each record seen ahead of its transfer edge
	initial begin : sink
		int          ready_idx;
		logic [39:0] exp_rec;
		logic [31:0] exp_ins;
		ready_idx   = 0;
		i_res_ready = 1'b1;
		forever begin
			@(negedge i_clk);
			if (rand_ready) begin
				i_res_ready = ready_pat[ready_idx];
				ready_idx   = (ready_idx + 1) % PAT_LEN;
			end else
				i_res_ready = 1'b1;
			if (o_res_valid === 1'b1 && i_res_ready) begin
				if (exp_q.size() == 0) begin
					other_count++;
					$display("output record at time %0t with no instruction pending", $time);
				end else begin
					exp_rec = exp_q.pop_front();
					exp_ins = ins_q.pop_front();
					check($sformatf("record of %h", exp_ins),
						{o_res_rd, o_res_data, o_res_we, o_res_taken, o_res_ex}, exp_rec);
				end
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		i_rst       = 1'b1;
		i_in_valid  = 1'b0;
		i_in_instr  = '0;
		i_in_pc     = '0;
		rand_ready  = 1'b0;
		err_count   = 0;
		other_count = 0;
		seed        = 39044;
		// back-pressure pattern drawn first
		for (int k = 0; k < PAT_LEN; k++)
			ready_pat[k] = ($random(seed) & 1) != 0;
		apply_reset();
		test_reg_ops();
		test_imm_ops();
		test_branches();
		test_jumps();
		test_exceptions();
		wait_drain();
		test_stream();
		apply_reset();
		$display("errors: %0d value mismatches, %0d other failures", err_count, other_count);
		if (err_count == 0 && other_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

module alu (
	input  rv_pkg::alu_fn_e                i_fn,
	input  logic [rv_pkg::XLEN-1:0]        i_a,
	input  logic [rv_pkg::XLEN-1:0]        i_b,
	output logic [rv_pkg::XLEN-1:0]        o_result,
	output logic                           o_cmp
);

	logic lt;
	logic ltu;
	logic eq;

	assign lt  = $signed(i_a) < $signed(i_b);
	assign ltu = i_a < i_b;
	assign eq  = (i_a == i_b);

	always_comb begin
		case (i_fn)
			rv_pkg::ALU_ADD:  o_result = i_a + i_b;
			rv_pkg::ALU_SUB:  o_result = i_a - i_b;
			// shift amount is b[4:0]
			rv_pkg::ALU_SLL:  o_result = i_a << i_b[4:0];
			rv_pkg::ALU_SRL:  o_result = i_a >> i_b[4:0];
			rv_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> i_b[4:0]);
			rv_pkg::ALU_SLT:  o_result = {31'b0, lt};
			rv_pkg::ALU_SLTU: o_result = {31'b0, ltu};
			rv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
			rv_pkg::ALU_OR:   o_result = i_a | i_b;
			rv_pkg::ALU_AND:  o_result = i_a & i_b;
			// compare only codes, result unused
			default:          o_result = {31'b0, o_cmp};
		endcase
	end

	// branch condition
	always_comb begin
		case (i_fn)
			rv_pkg::ALU_EQ:   o_cmp = eq;
			rv_pkg::ALU_NE:   o_cmp = ~eq;
			rv_pkg::ALU_SLT:  o_cmp = lt;
			rv_pkg::ALU_GE:   o_cmp = ~lt;
			rv_pkg::ALU_SLTU: o_cmp = ltu;
			rv_pkg::ALU_GEU:  o_cmp = ~ltu;
			default:          o_cmp = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/exec_core.sv
`default_nettype none

module exec_core (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_in_valid,
	input  logic [31:0] i_in_instr,
	input  logic [31:0] i_in_pc,
	output logic        o_in_ready,
	output logic        o_res_valid,
	input  logic        i_res_ready,
	output logic [4:0]  o_res_rd,
	output logic [31:0] o_res_data,
	output logic        o_res_we,
	output logic        o_res_taken,
	output logic        o_res_ex
);

	logic                          q_valid;
	logic [31:0]                   q_instr;
	logic [31:0]                   q_pc;
	logic                          q_pop;
	rv_pkg::alu_fn_e               alu_fn;
	rv_pkg::opb_sel_e              opb_sel;
	rv_pkg::fn_sel_e               fn_sel;
	logic                          dec_we;
	logic                          dec_btype;
	logic                          dec_use_pc;
	logic                          dec_ex;
	logic [rv_pkg::XLEN-1:0]       imm;
	logic [rv_pkg::REG_ADDR_W-1:0] rs1;
	logic [rv_pkg::REG_ADDR_W-1:0] rs2;
	logic [rv_pkg::REG_ADDR_W-1:0] rd;
	logic [rv_pkg::XLEN-1:0]       rs1_data;
	logic [rv_pkg::XLEN-1:0]       rs2_data;
	logic [rv_pkg::XLEN-1:0]       opa;
	logic [rv_pkg::XLEN-1:0]       opb;
	logic [rv_pkg::XLEN-1:0]       alu_res;
	logic                          alu_cmp;
	logic [rv_pkg::XLEN-1:0]       wb_data;
	logic                          rf_we;

	instr_queue u_queue (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_in_valid (i_in_valid),
		.i_in_instr (i_in_instr),
		.i_in_pc    (i_in_pc),
		.o_in_ready (o_in_ready),
		.o_q_valid  (q_valid),
		.o_q_instr  (q_instr),
		.o_q_pc     (q_pc),
		.i_q_pop    (q_pop)
	);

	instr_decoder u_dec (
		.i_instr   (q_instr),
		.o_alu_fn  (alu_fn),
		.o_opb_sel (opb_sel),
		.o_fn_sel  (fn_sel),
		.o_we      (dec_we),
		.o_btype   (dec_btype),
		.o_use_pc  (dec_use_pc),
		.o_ex      (dec_ex)
	);

	imm_gen u_imm (
		.i_instr (q_instr),
		.o_imm   (imm)
	);

	// register fields of the head instruction
	assign rs1 = q_instr[19:15];
	assign rs2 = q_instr[24:20];
	assign rd  = q_instr[11:7];

	// pop when the output slot is free or draining this edge
	assign q_pop = q_valid & (~o_res_valid | i_res_ready);
	assign rf_we = q_pop & dec_we & ~dec_ex & (rd != '0);

	regfile u_rf (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_rs1      (rs1),
		.i_rs2      (rs2),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.i_we       (rf_we),
		.i_rd       (rd),
		.i_rd_data  (wb_data)
	);

	// operand a is pc only for auipc
	assign opa = dec_use_pc ? q_pc : rs1_data;

	always_comb begin
		case (opb_sel)
			rv_pkg::OPB_IMM:   opb = imm;
			rv_pkg::OPB_SHAMT: opb = {27'b0, imm[4:0]};
			default:           opb = rs2_data;
		endcase
	end

	alu u_alu (
		.i_fn     (alu_fn),
		.i_a      (opa),
		.i_b      (opb),
		.o_result (alu_res),
		.o_cmp    (alu_cmp)
	);

	// pc+imm comes out of the alu with pc on operand a
	always_comb begin
		case (fn_sel)
			rv_pkg::FN_PC4: wb_data = q_pc + 32'd4;
			rv_pkg::FN_IMM: wb_data = imm;
			default:        wb_data = alu_res;
		endcase
	end

	// output record, valid is the only control bit
	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_res_valid <= 1'b0;
		else if (q_pop)
			o_res_valid <= 1'b1;
		else if (i_res_ready)
			o_res_valid <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (q_pop) begin
			o_res_rd    <= rd;
			// data zeroed when nothing is written back
			o_res_data  <= dec_we ? wb_data : '0;
			o_res_we    <= dec_we;
			o_res_taken <= dec_btype & alu_cmp & ~dec_ex;
			o_res_ex    <= dec_ex;
		end
	end

	// record held while the sink stalls
	a_res_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_res_valid && !i_res_ready) |=> (o_res_valid &&
		$stable({o_res_rd, o_res_data, o_res_we, o_res_taken, o_res_ex})));

endmodule

`default_nettype wire

//--- verilog/instr_queue.sv
`default_nettype none

module instr_queue (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_in_valid,
	input  logic [31:0] i_in_instr,
	input  logic [31:0] i_in_pc,
	output logic        o_in_ready,
	output logic        o_q_valid,
	output logic [31:0] o_q_instr,
	output logic [31:0] o_q_pc,
	input  logic        i_q_pop
);

	// two entry storage, payload only
	logic [31:0] instr_mem [2];
	logic [31:0] pc_mem [2];
	logic        wr_ptr;
	logic        rd_ptr;
	logic [1:0]  count;
	logic        push;

	// ready only looks at the fill level
	assign o_in_ready = (count != 2'd2);
	assign push       = i_in_valid & o_in_ready;

	// head entry straight to execute
	assign o_q_valid = (count != 2'd0);
	assign o_q_instr = instr_mem[rd_ptr];
	assign o_q_pc    = pc_mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (push) begin
			instr_mem[wr_ptr] <= i_in_instr;
			pc_mem[wr_ptr]    <= i_in_pc;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (i_q_pop)
				rd_ptr <= ~rd_ptr;
			// push and pop together leave the count alone
			case ({push, i_q_pop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	// execute never pops an empty queue
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
		i_q_pop |-> o_q_valid);

	a_count_max: assert property (@(posedge i_clk) disable iff (i_rst)
		count <= 2'd2);

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none

module regfile (
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
	input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
	output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
	output logic [rv_pkg::XLEN-1:0]       o_rs2_data,
	input  logic                          i_we,
	input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
	input  logic [rv_pkg::XLEN-1:0]       i_rd_data
);

	logic [rv_pkg::XLEN-1:0] regs [32];

	// all registers cleared on reset
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_we) begin
			regs[i_rd] <= i_rd_data;
		end
	end

	// x0 forced to zero on read
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

	// core filters rd == 0 before the write port
	a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
		i_we |-> (i_rd != '0));

endmodule

`default_nettype wire
